// ==== photon_counter_top.f ====
hw/photon_counter_pkg.sv
hw/photon_edge_detect.sv
hw/photon_gate_counter.sv
hw/count_byte_serializer.sv
hw/uart_tx.sv
hw/photon_counter_top.sv
testbench/photon_counter_checker.sv
testbench/tb_photon_counter.sv

// ==== testbench/tb_photon_counter.sv ====
`timescale 1ns/100ps

module tb_photon_counter;

    localparam int clk_period     = 100;   // ns.
    localparam int gate_unit      = 100;
    localparam int timeout_cycles = 3000;
    localparam int baud           = 4;
    localparam int reset_cycles   = 4;
    localparam int sync_period    = 2000;  // Twenty short gates.
    localparam int sync_high      = 50;
    localparam int abort_offset   = 1050;  // Lands inside the eleventh gate.
    localparam int quiet_cycles   = 500;
    localparam int guard_cycles   = 100;
    localparam int total_syncs    = 12;
    // Whole run, then doubled for the watchdog.
    localparam int run_cycles = reset_cycles + quiet_cycles + total_syncs * sync_period
                              + abort_offset + 5 * (timeout_cycles + 2 * guard_cycles);
    localparam int margin = 2;

    logic clk_133MHz_210;
    logic rst_n;
    logic photon_pulse;
    logic sync_50hz;
    logic [photon_counter_pkg::interval_sel_width-1:0] interval_sel;
    logic uart_txd;
    logic sync_lost;
    int   test_idx;
    logic test_end;
    logic wait_fault;
    logic drained;
    int   tests_run, tests_failed, err_total;
    logic photon_en;
    logic [15:0] lfsr_q;

    always #(clk_period / 2) clk_133MHz_210 = ~clk_133MHz_210;

    // Fibonacci, x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        lfsr_next = {state[14:0], fb};
    endfunction

    // One new photon level per cycle.
    always @(negedge clk_133MHz_210) begin
        if (photon_en) begin
            lfsr_q       = lfsr_next(lfsr_q);
            photon_pulse = lfsr_q[0];
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk_133MHz_210);
    endtask

    task automatic send_sync_edges(input int n, input int period);
        repeat (n) begin
            sync_50hz = 1'b1;
            idle_cycles(sync_high);
            sync_50hz = 1'b0;
            idle_cycles(period - sync_high);
        end
    endtask

    task automatic note_wait_fault();
        wait_fault = 1'b1;
        @(negedge clk_133MHz_210);
        wait_fault = 1'b0;
    endtask

    task automatic wait_for_sync_lost(input int limit);
        int n;
        n = 0;
        while (!sync_lost && n < limit) begin
            @(negedge clk_133MHz_210);
            n++;
        end
        if (!sync_lost) begin
            $display("sync_lost still low %0d cycles later, at %0t", limit, $time);
            note_wait_fault();
        end
    endtask

    // Lets the last frames land, then closes the test.
    task automatic end_test(input int idx);
        int n;
        n = 0;
        test_idx = idx;
        while (!drained && n < 4 * guard_cycles) begin
            @(negedge clk_133MHz_210);
            n++;
        end
        if (!drained) begin
            $display("expected counts still outstanding at %0t", $time);
            note_wait_fault();
        end
        idle_cycles(guard_cycles);  // Catches stray frames.
        test_end = 1'b1;
        @(negedge clk_133MHz_210);
        test_end = 1'b0;
    endtask

    photon_counter_top #(
        .gate_unit_cycles    (gate_unit),
        .sync_timeout_cycles (timeout_cycles),
        .baud_div            (baud)
    ) i_dut (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .photon_pulse   (photon_pulse),
        .sync_50hz      (sync_50hz),
        .interval_sel   (interval_sel),
        .uart_txd       (uart_txd),
        .sync_lost      (sync_lost)
    );

    photon_counter_checker #(
        .gate_unit_cycles    (gate_unit),
        .sync_timeout_cycles (timeout_cycles),
        .baud_div            (baud)
    ) i_chk (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .photon_pulse   (photon_pulse),
        .sync_50hz      (sync_50hz),
        .interval_sel   (interval_sel),
        .uart_txd       (uart_txd),
        .sync_lost      (sync_lost),
        .test_idx       (test_idx),
        .test_end       (test_end),
        .wait_fault     (wait_fault),
        .drained        (drained),
        .tests_run      (tests_run),
        .tests_failed   (tests_failed),
        .err_total      (err_total)
    );

    initial begin
        #(run_cycles * margin * clk_period);
        $display("run stopped by the watchdog after %0d cycles", run_cycles * margin);
        $display("Some tests failed");
        $finish;
    end

    ////////////////////////////////////////
    // Test sequence.
    ////////////////////////////////////////
    initial begin
        clk_133MHz_210 = 1'b0;
        rst_n          = 1'b0;
        photon_pulse   = 1'b0;
        sync_50hz      = 1'b0;
        interval_sel   = '0;
        test_idx       = 0;
        test_end       = 1'b0;
        wait_fault     = 1'b0;
        photon_en      = 1'b0;
        lfsr_q         = 16'd27176;
        idle_cycles(reset_cycles);
        rst_n     = 1'b1;
        photon_en = 1'b1;

        idle_cycles(quiet_cycles);  // Photons, no sync.
        end_test(1);

        // interval_sel only moves while gating is stopped.
        interval_sel = 2'd0;
        send_sync_edges(3, sync_period);
        wait_for_sync_lost(timeout_cycles + guard_cycles);
        end_test(2);

        // Every 10000-cycle gate is cut short, by sync or watchdog.
        interval_sel = 2'd1;
        send_sync_edges(4, sync_period);
        wait_for_sync_lost(timeout_cycles + guard_cycles);
        end_test(3);

        interval_sel = 2'd0;
        send_sync_edges(1, sync_period);
        sync_50hz = 1'b1;  // Last edge, then silence.
        idle_cycles(sync_high);
        sync_50hz = 1'b0;
        wait_for_sync_lost(timeout_cycles + 3 + 1 - sync_high);  // Three-cycle input delay.
        end_test(4);

        send_sync_edges(1, abort_offset);  // Next edge aborts a gate.
        send_sync_edges(3, sync_period);
        wait_for_sync_lost(timeout_cycles + guard_cycles);
        end_test(5);

        photon_en = 1'b0;
        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, err_total);
        if (tests_run == 5 && tests_failed == 0 && err_total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== testbench/photon_counter_checker.sv ====
`timescale 1ns/100ps

module photon_counter_checker #(
    parameter int gate_unit_cycles    = 100,
    parameter int sync_timeout_cycles = 3000,
    parameter int baud_div            = 4
) (
    input  logic                                            clk_133MHz_210,
    input  logic                                            rst_n,
    input  logic                                            photon_pulse,
    input  logic                                            sync_50hz,
    input  logic [photon_counter_pkg::interval_sel_width-1:0] interval_sel,
    input  logic                                            uart_txd,
    input  logic                                            sync_lost,
    input  int                                              test_idx,
    input  logic                                            test_end,    // One-cycle strobe.
    input  logic                                            wait_fault,  // Failed wait in the tb.
    output logic                                            drained,
    output int                                              tests_run,
    output int                                              tests_failed,
    output int                                              err_total
);

    localparam int hist_depth = 65536;  // Cycles of photon history.
    localparam int lat        = 3;      // Edge detector depth.

    logic       edge_hist [hist_depth];  // Sampled photon edge per cycle.
    int         exp_q [$];               // Counts still to arrive.
    int         cyc;
    logic       ph_prev, sy_prev;
    logic       ph_edge, sy_edge;
    logic       lost;                    // Model sync_lost, input timing.
    logic [lat:0] lost_dly;              // Same, delayed to DUT timing.
    int         last_sync, win_start, win_len;
    int         test_errs, test_frames;
    logic       rx_busy;                 // UART frame being decoded.
    int         rx_cnt, bit_no;
    logic [7:0] rx_shift, hi_byte;
    logic       have_hi;                 // High byte waiting for its pair.

    initial begin
        drained = 1'b0;
        rx_busy = 1'b0;
        have_hi = 1'b0;
    end

    ////////////////////////////////////////
    // Reference.
    ////////////////////////////////////////
    function automatic int gate_len(input logic [1:0] sel);
        case (sel)
            2'd0:    gate_len = gate_unit_cycles;          // 100 us.
            2'd1:    gate_len = gate_unit_cycles * 100;    // 10 ms.
            2'd2:    gate_len = gate_unit_cycles * 1000;   // 100 ms.
            default: gate_len = gate_unit_cycles * 10000;  // 1000 ms.
        endcase
    endfunction

    // Edges in [start, start + len), stuck at all ones.
    function automatic int expected_count(input int start, input int len);
        int n;
        n = 0;
        for (int i = start; i < start + len; i++) begin
            if (edge_hist[i % hist_depth]) n++;
        end
        if (n > 65535) n = 65535;
        expected_count = n;
    endfunction

    function automatic string test_name(input int idx);
        case (idx)
            1:       test_name = "idle before sync";
            2:       test_name = "100-cycle gates";
            3:       test_name = "10000-cycle gates";
            4:       test_name = "sync stopped";
            5:       test_name = "sync resumed, gate aborted";
            default: test_name = "unnamed";
        endcase
    endfunction

    task automatic flag_error();
        test_errs++;
        err_total++;
    endtask

    // Pairs bytes, high first, and checks each count.
    task automatic take_byte(input logic [7:0] b);
        int got;
        int exp;
        if (!have_hi) begin
            hi_byte = b;
            have_hi = 1'b1;
        end else begin
            have_hi = 1'b0;
            got = {hi_byte, b};
            test_frames++;
            if (exp_q.size() == 0) begin
                $display("unexpected count %0d arrived at %0t", got, $time);
                flag_error();
            end else begin
                exp = exp_q.pop_front();
                if (exp != got) begin
                    $display("mismatch at %0t: count on uart_txd expected %0d got %0d",
                             $time, exp, got);
                    flag_error();
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // Input model and sync_lost compare.
    ////////////////////////////////////////
    always @(posedge clk_133MHz_210) begin
        if (!rst_n) begin
            cyc       = 0;
            ph_prev   = 1'b0;
            sy_prev   = 1'b0;
            lost      = 1'b1;  // Lost until the first sync.
            lost_dly  = '1;
            last_sync = 0;
        end else begin
            ph_edge = photon_pulse && !ph_prev;
            sy_edge = sync_50hz && !sy_prev;
            ph_prev = photon_pulse;
            sy_prev = sync_50hz;
            edge_hist[cyc % hist_depth] = ph_edge;
            if (sy_edge) begin
                lost      = 1'b0;  // Gate restarts here.
                last_sync = cyc;
                win_start = cyc;
                win_len   = gate_len(interval_sel);
            end else if (!lost && cyc - last_sync == sync_timeout_cycles) begin
                lost = 1'b1;  // Open gate is dropped.
            end else if (!lost && cyc == win_start + win_len - 1) begin
                exp_q.push_back(expected_count(win_start, win_len));
                win_start = cyc + 1;  // Back to back.
                win_len   = gate_len(interval_sel);
            end
            if (sync_lost !== lost_dly[lat]) begin
                $display("mismatch at %0t: sync_lost expected %b got %b",
                         $time, lost_dly[lat], sync_lost);
                flag_error();
            end
            lost_dly = {lost_dly[lat-1:0], lost};
            cyc++;
        end
    end

    ////////////////////////////////////////
    // UART decoder and test reports.
    ////////////////////////////////////////
    always @(posedge clk_133MHz_210) begin
        if (rst_n) begin
            if (!rx_busy) begin
                if (!uart_txd) begin
                    rx_busy = 1'b1;  // Start bit seen.
                    rx_cnt  = 0;
                end
            end else begin
                rx_cnt++;
                if (rx_cnt % baud_div == baud_div / 2) begin  // Mid bit.
                    bit_no = rx_cnt / baud_div;
                    if (bit_no == 0) begin
                        if (uart_txd) begin
                            $display("start bit ended early at %0t", $time);
                            flag_error();
                            rx_busy = 1'b0;
                        end
                    end else if (bit_no <= 8) begin
                        rx_shift = {uart_txd, rx_shift[7:1]};  // LSB first.
                    end else begin
                        rx_busy = 1'b0;
                        if (!uart_txd) begin
                            $display("stop bit missing at %0t", $time);
                            flag_error();
                        end else begin
                            take_byte(rx_shift);
                        end
                    end
                end
            end
            if (wait_fault) flag_error();
            if (test_end) begin
                if (have_hi) begin
                    $display("a high byte came without its low byte");
                    flag_error();
                    have_hi = 1'b0;
                end
                if (exp_q.size() != 0) begin
                    $display("%0d expected counts never arrived", exp_q.size());
                    flag_error();
                    exp_q.delete();
                end
                $display("test %0d (%s): %0d counts, %0d errors",
                         test_idx, test_name(test_idx), test_frames, test_errs);
                tests_run++;
                if (test_errs != 0) tests_failed++;
                test_errs   = 0;
                test_frames = 0;
            end
        end
        drained = (exp_q.size() == 0) && !rx_busy;
    end

endmodule

// ==== hw/photon_counter_top.sv ====
`timescale 1ns/100ps

module photon_counter_top #(
    parameter int gate_unit_cycles    = 13333,    // 100 us at 133.33 MHz.
    parameter int sync_timeout_cycles = 8000000,  // Three 20 ms periods.
    parameter int baud_div            = 1157      // 115200 baud.
) (
    input  logic                                            clk_133MHz_210,
    input  logic                                            rst_n,
    input  logic                                            photon_pulse,
    input  logic                                            sync_50hz,
    input  logic [photon_counter_pkg::interval_sel_width-1:0] interval_sel,
    output logic                                            uart_txd,
    output logic                                            sync_lost
);

    ////////////////////////////////////////
    // Pipeline wires.
    ////////////////////////////////////////
    logic photon_rise;
    logic sync_rise;
    logic count_valid;
    logic count_ready;
    photon_counter_pkg::count_word_t count;
    logic byte_valid;
    logic byte_ready;
    logic [photon_counter_pkg::byte_width-1:0] tx_byte;

    // Inputs into the clock domain.
    photon_edge_detect i_edge (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .photon_pulse   (photon_pulse),
        .sync_50hz      (sync_50hz),
        .photon_rise    (photon_rise),
        .sync_rise      (sync_rise)
    );

    // Sync-aligned gates.
    photon_gate_counter #(
        .gate_unit_cycles    (gate_unit_cycles),
        .sync_timeout_cycles (sync_timeout_cycles)
    ) i_gate (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .photon_rise    (photon_rise),
        .sync_rise      (sync_rise),
        .interval_sel   (interval_sel),
        .count_valid    (count_valid),
        .count_ready    (count_ready),
        .count          (count),
        .sync_lost      (sync_lost)
    );

    // Word to bytes.
    count_byte_serializer i_ser (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .count_valid    (count_valid),
        .count_ready    (count_ready),
        .count          (count),
        .byte_valid     (byte_valid),
        .byte_ready     (byte_ready),
        .tx_byte        (tx_byte)
    );

    uart_tx #(
        .baud_div (baud_div)
    ) i_uart (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .byte_valid     (byte_valid),
        .byte_ready     (byte_ready),
        .tx_byte        (tx_byte),
        .uart_txd       (uart_txd)
    );

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx #(
    parameter int baud_div = 1157  // 133.33 MHz / 115200.
) (
    input  logic                                      clk_133MHz_210,
    input  logic                                      rst_n,
    input  logic                                      byte_valid,
    output logic                                      byte_ready,
    input  logic [photon_counter_pkg::byte_width-1:0] tx_byte,
    output logic                                      uart_txd
);

    localparam int data_bits = photon_counter_pkg::uart_data_bits;
    localparam int baud_cw   = $clog2(baud_div + 1);
    localparam int idx_cw    = $clog2(data_bits + 2);

    logic               busy_q;    // Frame in progress.
    logic [baud_cw-1:0] baud_cnt;  // Cycle within one bit.
    logic [idx_cw-1:0]  bit_idx;   // 0 start, 1..8 data, 9 stop.
    logic [data_bits:0] shift_q;   // Data bits then stop bit.
    logic               txd_q;
    logic               bit_end;

    assign byte_ready = !busy_q;
    assign uart_txd   = txd_q;
    assign bit_end    = baud_cnt == baud_cw'(baud_div - 1);

    ////////////////////////////////////////
    // 8N1 shifter, LSB first.
    ////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            txd_q    <= 1'b1;  // Line idles high.
        end else if (!busy_q) begin
            if (byte_valid) begin
                busy_q   <= 1'b1;
                baud_cnt <= '0;
                bit_idx  <= '0;
                txd_q    <= 1'b0;  // Start bit.
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            if (bit_idx == idx_cw'(data_bits + 1)) begin
                busy_q <= 1'b0;  // Stop bit done, line stays high.
            end else begin
                bit_idx <= bit_idx + 1'b1;
                txd_q   <= shift_q[0];
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // Payload shifter.
    always_ff @(posedge clk_133MHz_210) begin
        if (!busy_q && byte_valid) begin
            shift_q <= {1'b1, tx_byte};
        end else if (busy_q && bit_end) begin
            shift_q <= {1'b1, shift_q[data_bits:1]};
        end
    end

    a_idle_high: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !busy_q |-> uart_txd);

endmodule

// ==== hw/count_byte_serializer.sv ====
`timescale 1ns/100ps

module count_byte_serializer (
    input  logic                                         clk_133MHz_210,
    input  logic                                         rst_n,
    input  logic                                         count_valid,
    output logic                                         count_ready,
    input  photon_counter_pkg::count_word_t              count,
    output logic                                         byte_valid,
    input  logic                                         byte_ready,
    output logic [photon_counter_pkg::byte_width-1:0]    tx_byte
);

    ////////////////////////////////////////
    // One word buffer, two bytes out.
    ////////////////////////////////////////
    photon_counter_pkg::count_word_t word_q;  // Held count.
    logic full_q;   // Word waiting to go out.
    logic phase_q;  // 0 = hi byte, 1 = lo byte.
    logic take_count;
    logic take_byte;

    assign count_ready = !full_q;  // Only when empty.
    assign take_count  = count_valid && count_ready;
    assign take_byte   = byte_valid && byte_ready;

    // Byte offered the cycle after the word arrives.
    assign byte_valid = full_q;
    assign tx_byte    = phase_q ? word_q.bytes.lo : word_q.bytes.hi;

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            full_q  <= 1'b0;
            phase_q <= 1'b0;
        end else if (take_count) begin
            full_q  <= 1'b1;
            phase_q <= 1'b0;  // High byte first.
        end else if (take_byte) begin
            if (phase_q) begin
                // Low byte gone, free again.
                full_q  <= 1'b0;
                phase_q <= 1'b0;
            end else begin
                phase_q <= 1'b1;
            end
        end
    end

    // Payload register.
    always_ff @(posedge clk_133MHz_210) begin
        if (take_count) begin
            word_q <= count;
        end
    end

    // Offered byte holds until the transmitter takes it.
    a_byte_hold: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        byte_valid && !byte_ready |=> byte_valid && $stable(tx_byte));

endmodule

// ==== hw/photon_gate_counter.sv ====
`timescale 1ns/100ps

module photon_gate_counter #(
    parameter int gate_unit_cycles    = 13333,    // Cycles per 100 us.
    parameter int sync_timeout_cycles = 8000000   // About three sync periods.
) (
    input  logic                                            clk_133MHz_210,
    input  logic                                            rst_n,
    input  logic                                            photon_rise,
    input  logic                                            sync_rise,
    input  logic [photon_counter_pkg::interval_sel_width-1:0] interval_sel,
    output logic                                            count_valid,
    input  logic                                            count_ready,
    output photon_counter_pkg::count_word_t                 count,
    output logic                                            sync_lost
);

    localparam int unit_cw = $clog2(gate_unit_cycles + 1);
    localparam int wd_cw   = $clog2(sync_timeout_cycles + 1);
    localparam int cw      = photon_counter_pkg::count_width;
    localparam int uw      = photon_counter_pkg::unit_idx_width;

    logic               gate_active;  // Gate running.
    logic [unit_cw-1:0] cycle_cnt;    // Cycle within one unit.
    logic [uw-1:0]      unit_cnt;     // Units done in this gate.
    logic [uw-1:0]      unit_last;    // Gate length minus one, in units.
    logic [uw-1:0]      sel_last;     // Length for the current selection.
    logic [cw-1:0]      photon_acc;   // Edges so far, this cycle excluded.
    logic [cw-1:0]      photon_sum;   // Including this cycle's edge.
    logic [wd_cw-1:0]   wd_cnt;       // Cycles since last sync edge.
    logic               unit_end;
    logic               gate_end;
    logic               wd_expire;
    logic               emit;

    assign sel_last   = photon_counter_pkg::interval_units[interval_sel] - 1'b1;
    // Saturating add.
    assign photon_sum = (photon_rise && photon_acc != photon_counter_pkg::count_max) ?
                        photon_acc + 1'b1 : photon_acc;
    assign unit_end   = cycle_cnt == unit_cw'(gate_unit_cycles - 1);
    assign gate_end   = gate_active && unit_end && (unit_cnt == unit_last);
    assign wd_expire  = !sync_lost && (wd_cnt == wd_cw'(sync_timeout_cycles - 1));
    // Sync edge and timeout both throw the gate away.
    assign emit       = gate_end && !sync_rise && !wd_expire;

    ////////////////////////////////////////
    // Gate timing and photon count.
    ////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            gate_active <= 1'b0;
            cycle_cnt   <= '0;
            unit_cnt    <= '0;
            unit_last   <= '0;
            photon_acc  <= '0;
        end else if (sync_rise) begin
            // Realign; this cycle is cycle 0 of the new gate.
            gate_active <= 1'b1;
            cycle_cnt   <= unit_cw'(1);
            unit_cnt    <= '0;
            unit_last   <= sel_last;
            photon_acc  <= cw'(photon_rise);
        end else if (wd_expire) begin
            gate_active <= 1'b0;  // Stop, nothing sent.
        end else if (gate_active) begin
            photon_acc <= photon_sum;
            if (unit_end) begin
                cycle_cnt <= '0;
                if (unit_cnt == unit_last) begin
                    // Next gate follows at once.
                    unit_cnt   <= '0;
                    unit_last  <= sel_last;
                    photon_acc <= '0;
                end else begin
                    unit_cnt <= unit_cnt + 1'b1;
                end
            end else begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Count handshake.
    ////////////////////////////////////////
    // New count is dropped while one is still pending.
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            count_valid <= 1'b0;
        end else if (emit && (!count_valid || count_ready)) begin
            count_valid <= 1'b1;
        end else if (count_ready) begin
            count_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_133MHz_210) begin
        if (emit && (!count_valid || count_ready)) begin
            count.value <= photon_sum;
        end
    end

    // Sync watchdog. High from reset until the first edge.
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            wd_cnt    <= '0;
            sync_lost <= 1'b1;
        end else if (sync_rise) begin
            wd_cnt    <= '0;
            sync_lost <= 1'b0;
        end else if (wd_expire) begin
            sync_lost <= 1'b1;
        end else if (!sync_lost) begin
            wd_cnt <= wd_cnt + 1'b1;
        end
    end

    // Pending count must not change under the serializer.
    a_count_hold: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        count_valid && !count_ready |=> count_valid && $stable(count));

    a_sel_known: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        !$isunknown(interval_sel));

endmodule

// ==== hw/photon_edge_detect.sv ====
`timescale 1ns/100ps

module photon_edge_detect (
    input  logic clk_133MHz_210,
    input  logic rst_n,
    input  logic photon_pulse,  // Asynchronous, from the detector.
    input  logic sync_50hz,     // Asynchronous, mains sync.
    output logic photon_rise,
    output logic sync_rise
);

    ////////////////////////////////////////
    // Both lines share one pipeline.
    ////////////////////////////////////////
    // Bit 0 is photon, bit 1 is sync.
    logic [1:0] async_in;
    logic [1:0] meta_q;   // First synchronizer flop.
    logic [1:0] sync_q;   // Second synchronizer flop.
    logic [1:0] prev_q;   // Last cycle's level.
    logic [1:0] rise_q;   // Registered edge pulses.

    assign async_in = {sync_50hz, photon_pulse};

    // Two flops against metastability.
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            meta_q <= '0;
            sync_q <= '0;
            prev_q <= '0;
        end else begin
            meta_q <= async_in;
            sync_q <= meta_q;
            prev_q <= sync_q;
        end
    end

    // High for one cycle per rising edge.
    // Same depth on both bits, so relative timing holds.
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            rise_q <= '0;
        end else begin
            rise_q <= sync_q & ~prev_q;
        end
    end

    assign photon_rise = rise_q[0];
    assign sync_rise   = rise_q[1];

endmodule

// ==== hw/photon_counter_pkg.sv ====
package photon_counter_pkg;

    ////////////////////////////////////////
    // Widths.
    ////////////////////////////////////////
    localparam int count_width        = 16;  // One photon count.
    localparam int byte_width         = 8;   // One UART data byte.
    localparam int interval_sel_width = 2;   // Four gate lengths.
    localparam int unit_idx_width     = 14;  // Holds up to 10000 units.

    // Count word, split into bytes for the UART.
    typedef struct packed {
        logic [byte_width-1:0] hi;  // Sent first.
        logic [byte_width-1:0] lo;
    } count_bytes_t;

    // Gate counter writes value, serializer reads bytes.
    typedef union packed {
        logic [count_width-1:0] value;
        count_bytes_t           bytes;
    } count_word_t;

    ////////////////////////////////////////
    // Gate lengths in 100 us units.
    ////////////////////////////////////////
    // 100 us, 10 ms, 100 ms, 1000 ms.
    localparam logic [unit_idx_width-1:0] interval_units [4] = '{
        14'd1,
        14'd100,
        14'd1000,
        14'd10000
    };

    // Counts stick here.
    localparam logic [count_width-1:0] count_max = '1;

    // 8N1 frame.
    localparam int uart_data_bits = 8;

endpackage
